// File: sim.f
rob_pkg.sv
rob_ptr_ctrl.sv
rob_entries.sv
rob_commit_fsm.sv
rename_map.sv
rob_top.sv
tb_rob.sv

// File: Makefile
RTL = rob_pkg.sv rob_ptr_ctrl.sv rob_entries.sv rob_commit_fsm.sv rename_map.sv rob_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module rob_top $(RTL)

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_rob -f sim.f
	./obj_dir/Vtb_rob | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: tb_rob.sv
`timescale 1ns/1ps

module tb_rob;
    import rob_pkg::*;

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        op_kind_e          kind;
        logic              wr;
        logic [reg_w-1:0]  rd;
        logic              pred;
        logic              taken;
        logic [data_w-1:0] data;
        logic [addr_w-1:0] target;
    } rec_t;

    localparam int n_fill      = 32;
    localparam int n_mixed     = 160;
    localparam int cycle_bound = 60; // cycles allowed per planned op

    logic               clk;
    logic               rst;
    logic               alloc_en   = 1'b0;
    alloc_t             alloc      = '0;
    logic               disp_en    = 1'b0;
    dispatch_t          disp       = '0;
    logic               ex_en      = 1'b0;
    wb_t                ex_wb      = '0;
    logic               lsb_en     = 1'b0;
    logic [tag_w-1:0]   lsb_tag    = '0;
    logic [data_w-1:0]  lsb_data   = '0;
    logic               store_done = 1'b0;
    logic [reg_w-1:0]   lookup_reg = '0;
    logic               full;
    logic               alloc_grant;
    logic [tag_w-1:0]   alloc_tag;
    logic               lookup_busy;
    logic [tag_w-1:0]   lookup_tag;
    logic               rf_en;
    retire_t            rf;
    logic               store_go;
    logic [tag_w-1:0]   store_tag;
    logic               redirect;
    logic [addr_w-1:0]  redirect_pc;

    // reference model state
    rec_t               exp_q [$];   // in program order
    rec_t               by_tag [rob_depth];
    logic [tag_w-1:0]   pending [$]; // granted, not yet completed
    rec_t               cur;
    logic [tag_w-1:0]   exp_tail     = '0;
    int                 n_granted    = 0;
    int                 errors       = 0;
    logic               store_wait   = 1'b0;
    logic               flush_check  = 1'b0;
    logic               disp_pending = 1'b0;
    dispatch_t          disp_next    = '0;
    logic               complete_on  = 1'b0;
    logic [31:0]        ref_busy     = '0;
    logic [tag_w-1:0]   ref_tag [32];

    rob_top i_rob_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    function automatic logic mispredicts(input rec_t r);
        return r.kind == op_branch && r.pred != r.taken;
    endfunction

    // retires with no strobe at all
    function automatic logic is_silent(input rec_t r);
        return r.kind != op_store && !mispredicts(r) && !r.wr;
    endfunction

    function automatic int strobes_left();
        int n;
        n = 0;
        foreach (exp_q[i]) begin
            if (!is_silent(exp_q[i])) n++;
        end
        return n;
    endfunction

    task automatic pop_silent();
        while (exp_q.size() > 0 && is_silent(exp_q[0])) void'(exp_q.pop_front());
    endtask

    a_no_grant_full: assert property (@(posedge clk) disable iff (rst) full |-> !alloc_grant)
        else report_error("grant while full");
    a_store_excl: assert property (@(posedge clk) disable iff (rst)
        !(store_go && (rf_en || redirect)))
        else report_error("store_go together with another commit strobe");
    a_redirect_pulse: assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect)
        else report_error("redirect longer than one cycle");
    a_store_go_pulse: assert property (@(posedge clk) disable iff (rst) store_go |=> !store_go)
        else report_error("store_go longer than one cycle");

    // commit side and rename checks, then model updates for this edge
    always @(posedge clk) begin
        rec_t f;
        if (!rst) begin
            if (ref_busy[lookup_reg]) begin
                assert (lookup_busy && lookup_tag == ref_tag[lookup_reg])
                    else report_error($sformatf("lookup r%0d busy %0b tag %0d, expected tag %0d",
                                      lookup_reg, lookup_busy, lookup_tag, ref_tag[lookup_reg]));
            end else begin
                assert (!lookup_busy)
                    else report_error($sformatf("lookup r%0d busy, expected free", lookup_reg));
            end
            if (flush_check) begin
                assert (!full && !lookup_busy) else report_error("full or busy after flush");
                flush_check = 1'b0;
            end
            if (store_wait) begin
                assert (!rf_en && !store_go && !redirect)
                    else report_error("commit while the store waits for done");
            end
            if (rf_en) begin
                pop_silent();
                if (exp_q.size() == 0) begin
                    report_error("rf_en with nothing in flight");
                end else begin
                    f = exp_q.pop_front();
                    assert (f.kind != op_store && !mispredicts(f) && f.tag == rf.tag &&
                            f.rd == rf.rd && f.data == rf.data)
                        else report_error($sformatf("rf tag %0d rd %0d data %h, exp %0d %0d %h",
                                          rf.tag, rf.rd, rf.data, f.tag, f.rd, f.data));
                    if (ref_busy[f.rd] && ref_tag[f.rd] == f.tag) ref_busy[f.rd] = 1'b0;
                end
            end
            if (store_go) begin
                pop_silent();
                if (exp_q.size() == 0) begin
                    report_error("store_go with nothing in flight");
                end else begin
                    f = exp_q.pop_front();
                    assert (f.kind == op_store && f.tag == store_tag)
                        else report_error($sformatf("store_go tag %0d, expected tag %0d",
                                          store_tag, f.tag));
                end
                store_wait = 1'b1;
            end else if (store_wait && store_done) begin
                store_wait = 1'b0;
            end
            if (redirect) begin
                pop_silent();
                if (exp_q.size() == 0) begin
                    report_error("redirect with nothing in flight");
                end else begin
                    f = exp_q.pop_front();
                    assert (mispredicts(f) && redirect_pc == f.target)
                        else report_error($sformatf("redirect to %h, expected %h on tag %0d",
                                          redirect_pc, f.target, f.tag));
                end
                exp_q.delete(); // younger entries are gone
                pending.delete();
                ref_busy     = '0;
                exp_tail     = '0;
                flush_check  = 1'b1;
                disp_pending = 1'b0;
            end
            if (alloc_grant) begin
                assert (alloc_tag == exp_tail)
                    else report_error($sformatf("granted tag %0d, expected %0d",
                                      alloc_tag, exp_tail));
                f     = cur;
                f.tag = alloc_tag;
                exp_q.push_back(f);
                by_tag[alloc_tag] = f;
                pending.push_back(alloc_tag);
                if (f.wr && f.rd != '0) begin
                    ref_busy[f.rd] = 1'b1;
                    ref_tag[f.rd]  = alloc_tag;
                end
                disp_pending   = 1'b1;
                disp_next.tag  = alloc_tag;
                disp_next.pred = f.pred;
                exp_tail       = exp_tail + tag_w'(1);
                n_granted++;
            end
        end
    end

    // dispatch, completions in random order, store done and lookups
    always @(negedge clk) begin
        int   idx;
        rec_t r;
        ex_en        = 1'b0;
        lsb_en       = 1'b0;
        store_done   = 1'b0;
        disp_en      = disp_pending;
        disp         = disp_next;
        disp_pending = 1'b0;
        lookup_reg   = reg_w'($urandom % 8);
        if (!rst && complete_on && pending.size() > 0 && $urandom % 2 == 0) begin
            idx = $urandom % pending.size();
            r   = by_tag[pending[idx]];
            if (r.kind != op_load) begin
                ex_en        = 1'b1;
                ex_wb.tag    = r.tag;
                ex_wb.data   = r.data;
                ex_wb.taken  = r.taken;
                ex_wb.target = r.target;
                pending.delete(idx);
            end
        end
        if (!rst && complete_on && pending.size() > 0 && $urandom % 2 == 0) begin
            idx = $urandom % pending.size();
            r   = by_tag[pending[idx]];
            if (r.kind == op_load) begin
                lsb_en   = 1'b1;
                lsb_tag  = r.tag;
                lsb_data = r.data;
                pending.delete(idx);
            end
        end
        if (store_wait && $urandom % 4 == 0) store_done = 1'b1;
    end

    task automatic make_record(input logic allow_mispredict);
        cur.tag    = '0;
        cur.kind   = op_kind_e'(2'($urandom));
        cur.rd     = reg_w'($urandom % 8); // few registers, many rename collisions
        cur.wr     = (cur.kind != op_store) && ($urandom % 4 != 0);
        cur.pred   = 1'($urandom);
        cur.taken  = cur.pred;
        cur.data   = $urandom;
        cur.target = $urandom;
        if (cur.kind == op_branch && allow_mispredict && $urandom % 6 == 0) begin
            cur.taken = !cur.pred;
        end
    endtask

    // caller sits at a falling edge
    task automatic issue_one(input logic allow_mispredict);
        int start;
        start = n_granted;
        make_record(allow_mispredict);
        alloc_en   = 1'b1;
        alloc.rd   = cur.rd;
        alloc.wr   = cur.wr;
        alloc.kind = cur.kind;
        do @(negedge clk); while (n_granted == start);
        alloc_en = 1'b0;
    endtask

    task automatic drain();
        while (strobes_left() > 0 || store_wait) @(negedge clk);
        repeat (8) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'haeacf9ed));
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!full && !alloc_grant && !rf_en && !store_go && !redirect && !lookup_busy)
            else report_error("control output high after reset");

        // fill without completions
        repeat (n_fill) issue_one(1'b0);
        assert (full) else report_error("full low after 32 grants");
        alloc_en = 1'b1;
        repeat (4) @(negedge clk);
        alloc_en = 1'b0;
        assert (n_granted == n_fill) else report_error("grant while full");
        complete_on = 1'b1;
        drain();

        repeat (n_mixed) issue_one(1'b1);
        drain();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((n_fill + n_mixed) * cycle_bound * 20);
        $display("timeout: the run did not finish within the cycle bound");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: rob_top.sv
`timescale 1ns/1ps

module rob_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alloc_en,
    input  rob_pkg::alloc_t            alloc,
    input  logic                       disp_en,
    input  rob_pkg::dispatch_t         disp,
    input  logic                       ex_en,
    input  rob_pkg::wb_t               ex_wb,
    input  logic                       lsb_en,
    input  logic [rob_pkg::tag_w-1:0]  lsb_tag,
    input  logic [rob_pkg::data_w-1:0] lsb_data,
    input  logic                       store_done,
    input  logic [rob_pkg::reg_w-1:0]  lookup_reg,
    output logic                       full,
    output logic                       alloc_grant,
    output logic [rob_pkg::tag_w-1:0]  alloc_tag,
    output logic                       lookup_busy,
    output logic [rob_pkg::tag_w-1:0]  lookup_tag,
    output logic                       rf_en,
    output rob_pkg::retire_t           rf,
    output logic                       store_go,
    output logic [rob_pkg::tag_w-1:0]  store_tag,
    output logic                       redirect,
    output logic [rob_pkg::addr_w-1:0] redirect_pc
);
    import rob_pkg::*;

    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic             empty;
    logic             retire_head;
    logic             flush_all;
    entry_t           head_entry;

    assign alloc_tag = tail; // nick handed back to dispatch

    rob_ptr_ctrl i_rob_ptr_ctrl (
        .clk         (clk),
        .rst         (rst),
        .alloc_en    (alloc_en),
        .retire_head (retire_head),
        .flush_all   (flush_all),
        .head        (head),
        .tail        (tail),
        .full        (full),
        .empty       (empty),
        .alloc_grant (alloc_grant)
    );

    rob_entries i_rob_entries (
        .clk         (clk),
        .rst         (rst),
        .alloc_grant (alloc_grant),
        .tail        (tail),
        .alloc       (alloc),
        .disp_en     (disp_en),
        .disp        (disp),
        .ex_en       (ex_en),
        .ex_wb       (ex_wb),
        .lsb_en      (lsb_en),
        .lsb_tag     (lsb_tag),
        .lsb_data    (lsb_data),
        .head        (head),
        .retire_head (retire_head),
        .flush_all   (flush_all),
        .head_entry  (head_entry)
    );

    rob_commit_fsm i_rob_commit_fsm (
        .clk         (clk),
        .rst         (rst),
        .empty       (empty),
        .head        (head),
        .head_entry  (head_entry),
        .store_done  (store_done),
        .retire_head (retire_head),
        .flush_all   (flush_all),
        .rf_en       (rf_en),
        .rf          (rf),
        .store_go    (store_go),
        .store_tag   (store_tag),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    rename_map i_rename_map (
        .clk         (clk),
        .rst         (rst),
        .alloc_grant (alloc_grant),
        .alloc       (alloc),
        .alloc_tag   (tail),
        .rf_en       (rf_en),
        .rf          (rf),
        .flush_all   (flush_all),
        .lookup_reg  (lookup_reg),
        .lookup_busy (lookup_busy),
        .lookup_tag  (lookup_tag)
    );

endmodule

// File: rename_map.sv
`timescale 1ns/1ps

module rename_map (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc_grant,
    input  rob_pkg::alloc_t           alloc,
    input  logic [rob_pkg::tag_w-1:0] alloc_tag,
    input  logic                      rf_en,
    input  rob_pkg::retire_t          rf,
    input  logic                      flush_all,
    input  logic [rob_pkg::reg_w-1:0] lookup_reg,
    output logic                      lookup_busy,
    output logic [rob_pkg::tag_w-1:0] lookup_tag
);
    import rob_pkg::*;

    localparam int n_regs = 2 ** reg_w;

    logic [n_regs-1:0] busy;
    logic [tag_w-1:0]  tag_tbl [n_regs];

    logic alloc_wr;
    logic commit_hit;

    assign alloc_wr   = alloc_grant && alloc.wr && (alloc.rd != '0); // x0 stays free
    assign commit_hit = rf_en && busy[rf.rd] && (tag_tbl[rf.rd] == rf.tag);

    always_ff @(posedge clk) begin
        if (rst || flush_all) begin
            busy <= '0;
        end else begin
            if (commit_hit) begin
                busy[rf.rd] <= 1'b0;
            end
            if (alloc_wr) begin
                busy[alloc.rd] <= 1'b1; // newer producer wins over commit
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_wr) begin
            tag_tbl[alloc.rd] <= alloc_tag;
        end
    end

    assign lookup_busy = busy[lookup_reg];
    assign lookup_tag  = tag_tbl[lookup_reg];

endmodule

// File: rob_commit_fsm.sv
`timescale 1ns/1ps

module rob_commit_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       empty,
    input  logic [rob_pkg::tag_w-1:0]  head,
    input  rob_pkg::entry_t            head_entry,
    input  logic                       store_done,
    output logic                       retire_head,
    output logic                       flush_all,
    output logic                       rf_en,
    output rob_pkg::retire_t           rf,
    output logic                       store_go,
    output logic [rob_pkg::tag_w-1:0]  store_tag,
    output logic                       redirect,
    output logic [rob_pkg::addr_w-1:0] redirect_pc
);
    import rob_pkg::*;

    commit_state_e state;

    logic head_ready;
    logic is_store;
    logic is_mispredict;

    assign head_ready    = !empty && head_entry.valid && head_entry.done;
    assign is_store      = (head_entry.kind == op_store);
    assign is_mispredict = (head_entry.kind == op_branch) &&
                           (head_entry.taken != head_entry.pred);

    always_comb begin
        retire_head = 1'b0;
        flush_all   = 1'b0;
        unique case (state)
            st_idle:       retire_head = head_ready && !is_store && !is_mispredict;
            st_store_wait: retire_head = store_done; // store leaves on done
            st_flush:      flush_all   = 1'b1;
            default:       retire_head = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            rf_en    <= 1'b0;
            store_go <= 1'b0;
            redirect <= 1'b0;
        end else begin
            rf_en    <= 1'b0;
            store_go <= 1'b0;
            redirect <= 1'b0;
            unique case (state)
                st_idle: begin
                    if (head_ready) begin
                        if (is_store) begin
                            store_go <= 1'b1;
                            state    <= st_store_wait;
                        end else if (is_mispredict) begin
                            redirect <= 1'b1;
                            state    <= st_flush;
                        end else begin
                            rf_en <= head_entry.wr; // silent retire when clear
                        end
                    end
                end
                st_store_wait: begin
                    if (store_done) begin
                        state <= st_idle;
                    end
                end
                st_flush: state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // commit payloads
    always_ff @(posedge clk) begin
        if (state == st_idle && head_ready) begin
            rf.tag      <= head;
            rf.rd       <= head_entry.rd;
            rf.data     <= head_entry.data;
            store_tag   <= head;
            redirect_pc <= head_entry.target;
        end
    end

    a_redirect_rf_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(redirect && rf_en)
    ) else $error("rob_commit_fsm: redirect together with rf_en");

endmodule

// File: rob_entries.sv
`timescale 1ns/1ps

module rob_entries (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alloc_grant,
    input  logic [rob_pkg::tag_w-1:0]  tail,
    input  rob_pkg::alloc_t            alloc,
    input  logic                       disp_en,
    input  rob_pkg::dispatch_t         disp,
    input  logic                       ex_en,
    input  rob_pkg::wb_t               ex_wb,
    input  logic                       lsb_en,
    input  logic [rob_pkg::tag_w-1:0]  lsb_tag,
    input  logic [rob_pkg::data_w-1:0] lsb_data,
    input  logic [rob_pkg::tag_w-1:0]  head,
    input  logic                       retire_head,
    input  logic                       flush_all,
    output rob_pkg::entry_t            head_entry
);
    import rob_pkg::*;

    entry_t               mem [rob_depth];
    logic [rob_depth-1:0] valid_q;

    // valid bits live apart from the payload array
    always_ff @(posedge clk) begin
        if (rst || flush_all) begin
            valid_q <= '0;
        end else begin
            if (alloc_grant) begin
                valid_q[tail] <= 1'b1;
            end
            if (retire_head) begin
                valid_q[head] <= 1'b0;
            end
        end
    end

    // later writes to the payload win
    always_ff @(posedge clk) begin
        if (alloc_grant) begin
            mem[tail].done  <= 1'b0;
            mem[tail].kind  <= alloc.kind;
            mem[tail].wr    <= alloc.wr;
            mem[tail].rd    <= alloc.rd;
            mem[tail].pred  <= 1'b0; // not taken until dispatch says otherwise
            mem[tail].taken <= 1'b0;
        end

        if (disp_en) begin
            mem[disp.tag].pred <= disp.pred;
        end

        if (ex_en) begin
            mem[ex_wb.tag].done   <= 1'b1;
            mem[ex_wb.tag].data   <= ex_wb.data;
            mem[ex_wb.tag].taken  <= ex_wb.taken;
            mem[ex_wb.tag].target <= ex_wb.target;
        end

        if (lsb_en) begin
            mem[lsb_tag].done <= 1'b1; // load result
            mem[lsb_tag].data <= lsb_data;
        end
    end

    always_comb begin
        head_entry       = mem[head];
        head_entry.valid = valid_q[head];
    end

    // completions only land on live entries
    a_ex_live: assert property (
        @(posedge clk) disable iff (rst)
        ex_en |-> valid_q[ex_wb.tag]
    ) else $error("rob_entries: ex completion to invalid tag %0d", ex_wb.tag);

    a_lsb_live: assert property (
        @(posedge clk) disable iff (rst)
        lsb_en |-> valid_q[lsb_tag]
    ) else $error("rob_entries: lsb completion to invalid tag %0d", lsb_tag);

endmodule

// File: rob_ptr_ctrl.sv
`timescale 1ns/1ps

module rob_ptr_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc_en,
    input  logic                      retire_head,
    input  logic                      flush_all,
    output logic [rob_pkg::tag_w-1:0] head,
    output logic [rob_pkg::tag_w-1:0] tail,
    output logic                      full,
    output logic                      empty,
    output logic                      alloc_grant
);
    import rob_pkg::*;

    logic [cnt_w-1:0] count;

    assign full  = (count == cnt_w'(rob_depth));
    assign empty = (count == '0);

    // no grant while full or during the flush cycle
    assign alloc_grant = alloc_en && !full && !flush_all;

    always_ff @(posedge clk) begin
        if (rst || flush_all) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_grant) begin
                tail <= tail + tag_w'(1); // wraps after 31
            end
            if (retire_head) begin
                head <= head + tag_w'(1);
            end
            unique case ({alloc_grant, retire_head})
                2'b10:   count <= count + cnt_w'(1);
                2'b01:   count <= count - cnt_w'(1);
                default: count <= count; // both or neither
            endcase
        end
    end

    // occupancy never above depth
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= cnt_w'(rob_depth)
    ) else $error("rob_ptr_ctrl: count above depth");

    // commit side must never pop an empty buffer
    a_no_retire_empty: assert property (
        @(posedge clk) disable iff (rst)
        retire_head |-> !empty
    ) else $error("rob_ptr_ctrl: retire while empty");

endmodule

// File: rob_pkg.sv
package rob_pkg;

    localparam int rob_depth = 32;
    localparam int tag_w     = 5;
    localparam int reg_w     = 5;
    localparam int data_w    = 32;
    localparam int addr_w    = 32;
    localparam int cnt_w     = $clog2(rob_depth + 1); // holds 0..rob_depth

    typedef enum logic [1:0] {
        op_alu,
        op_load,
        op_store,
        op_branch
    } op_kind_e;

    typedef enum logic [1:0] {
        st_idle,
        st_store_wait,
        st_flush
    } commit_state_e;

    // request from decode
    typedef struct packed {
        logic [reg_w-1:0] rd;
        logic             wr;   // instruction writes rd
        op_kind_e         kind;
    } alloc_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic             pred; // predicted taken
    } dispatch_t;

    // completion from execution
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] data;
        logic              taken;
        logic [addr_w-1:0] target; // fall-through when not taken
    } wb_t;

    typedef struct packed {
        logic              valid;
        logic              done;
        op_kind_e          kind;
        logic              wr;
        logic [reg_w-1:0]  rd;
        logic [data_w-1:0] data;
        logic              pred;
        logic              taken;
        logic [addr_w-1:0] target;
    } entry_t;

    // register file commit
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [reg_w-1:0]  rd;
        logic [data_w-1:0] data;
    } retire_t;

endpackage
